/* verif/mem_unit_tests.txt */
# access name op(0 load, 1 store) priv(0 U, 1 S, 3 M) sum vaddr(hex) wdata(hex) code rdata(hex)
# fill name vtag(hex) ptag(hex) u w ; flush name ; code 0 ok 1 miss 2 load pf 3 store pf 4 access
access m_st_word      1 3 0 0040 11112222 0 00000000
access m_ld_word      0 3 0 0040 00000000 0 11112222
access m_ld_blank     0 3 0 0080 00000000 0 00000000
access m_ld_high_bits 0 3 0 2040 00000000 0 11112222
fill   map_a          10 03 0 1
fill   map_b          20 03 0 1
access s_st_page_a    1 1 0 1004 a5a5a5a5 0 00000000
access s_ld_page_b    0 1 0 2004 00000000 0 a5a5a5a5
access m_ld_phys_3    0 3 0 0304 00000000 0 a5a5a5a5
access s_ld_unmapped  0 1 0 3000 00000000 1 00000000
flush  flush_all
access s_ld_flushed   0 1 0 1004 00000000 1 00000000
access s_st_flushed   1 1 0 2008 deadbeef 1 00000000
access m_ld_untouched 0 3 0 0308 00000000 0 00000000
fill   map_user       40 05 1 1
fill   map_super      41 06 0 1
fill   map_readonly   42 07 1 0
access u_st_user      1 0 0 4010 00c0ffee 0 00000000
access u_ld_user      0 0 0 4010 00000000 0 00c0ffee
access u_ld_super     0 0 0 4110 00000000 2 00000000
access u_st_super     1 0 0 4110 12345678 3 00000000
access s_ld_super     0 1 0 4110 00000000 0 00000000
access s_ld_nosum     0 1 0 4010 00000000 2 00000000
access s_st_nosum     1 1 0 4010 ffffffff 3 00000000
access s_ld_sum       0 1 1 4010 00000000 0 00c0ffee
access s_st_readonly  1 1 1 4220 87654321 3 00000000
access u_st_readonly  1 0 0 4220 87654321 3 00000000
access s_ld_readonly  0 1 1 4220 00000000 0 00000000
fill   map_far        50 12 0 1
access s_st_far       1 1 0 5020 cafef00d 4 00000000
access s_ld_far       0 1 0 5020 00000000 4 00000000
access m_ld_far       0 3 0 1220 00000000 4 00000000
access m_ld_far_alias 0 3 0 0220 00000000 0 00000000
access b_st_0         1 3 0 0100 00000001 0 00000000
access b_st_1         1 3 0 0104 00000002 0 00000000
access b_ld_0         0 3 0 0100 00000000 0 00000001
access b_ld_1         0 3 0 0104 00000000 0 00000002
access b_ld_unaligned 0 3 0 0107 00000000 0 00000002
access b_u_miss       0 0 0 6000 00000000 1 00000000
access b_ld_user      0 0 0 4014 00000000 0 00000000

/* list.f */
rtl/mem_unit_pkg.sv
rtl/mem_cmd_accept.sv
rtl/mem_translate.sv
rtl/mem_fault_check.sv
rtl/mem_data_stage.sv
rtl/mem_resp_send.sv
rtl/mem_unit_top.sv
verif/mem_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module mem_unit_tb \
  -f list.f -o mem_unit_sim \
  && ./obj_dir/mem_unit_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log || { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

/* verif/mem_unit_tb.sv */
// Testbench for the memory unit driving file-based commands and checking each response
`timescale 1ns/10ps
`default_nettype none

module mem_unit_tb
  import mem_unit_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 500;
  localparam int KIND_W         = 64;
  localparam int NAME_W         = 8 * 24;

  localparam logic [KIND_W-1:0] KIND_NOTE   = KIND_W'("#");
  localparam logic [KIND_W-1:0] KIND_FILL   = KIND_W'("fill");
  localparam logic [KIND_W-1:0] KIND_FLUSH  = KIND_W'("flush");
  localparam logic [KIND_W-1:0] KIND_ACCESS = KIND_W'("access");

  logic               clk_i = 1'b0;
  logic               reset_i;
  logic               cmd_req_i;
  mem_op_e            cmd_op_i;
  logic [VADDR_W-1:0] cmd_vaddr_i;
  logic [DATA_W-1:0]  cmd_wdata_i;
  priv_e              priv_i;
  logic               sum_i;
  logic               cmd_ack_o;
  logic               tlb_fill_v_i;
  logic [VTAG_W-1:0]  tlb_fill_vtag_i;
  logic [PTAG_W-1:0]  tlb_fill_ptag_i;
  logic               tlb_fill_u_i;
  logic               tlb_fill_w_i;
  logic               tlb_flush_i;
  logic               resp_req_o;
  resp_code_e         resp_code_o;
  logic [DATA_W-1:0]  resp_rdata_o;
  logic               resp_ack_i;

  // Expected responses in command order
  logic [NAME_W-1:0] name_q [$];
  logic [2:0]        code_q [$];
  logic [DATA_W-1:0] rdata_q [$];

  integer seed;
  int     checked = 0;

  always #50 clk_i = ~clk_i;

  mem_unit_top dut0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_req_i       (cmd_req_i),
    .cmd_op_i        (cmd_op_i),
    .cmd_vaddr_i     (cmd_vaddr_i),
    .cmd_wdata_i     (cmd_wdata_i),
    .priv_i          (priv_i),
    .sum_i           (sum_i),
    .cmd_ack_o       (cmd_ack_o),
    .tlb_fill_v_i    (tlb_fill_v_i),
    .tlb_fill_vtag_i (tlb_fill_vtag_i),
    .tlb_fill_ptag_i (tlb_fill_ptag_i),
    .tlb_fill_u_i    (tlb_fill_u_i),
    .tlb_fill_w_i    (tlb_fill_w_i),
    .tlb_flush_i     (tlb_flush_i),
    .resp_req_o      (resp_req_o),
    .resp_code_o     (resp_code_o),
    .resp_rdata_o    (resp_rdata_o),
    .resp_ack_i      (resp_ack_i)
  );

  task automatic report_error(input string msg);
    $display("%0s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic send_command(input logic op, input logic [1:0] priv, input logic sum,
                              input logic [VADDR_W-1:0] vaddr, input logic [DATA_W-1:0] wdata);
    int n;
    @(posedge clk_i);
    cmd_req_i   <= 1'b1;
    cmd_op_i    <= mem_op_e'(op);
    priv_i      <= priv_e'(priv);
    sum_i       <= sum;
    cmd_vaddr_i <= vaddr;
    cmd_wdata_i <= wdata;
    n = 0;
    @(posedge clk_i);
    while (!cmd_ack_o && n < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      n++;
    end
    assert (cmd_ack_o) else report_error("timeout waiting for the command ack");
    cmd_req_i <= 1'b0;
    n = 0;
    @(posedge clk_i);
    while (cmd_ack_o && n < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      n++;
    end
    assert (!cmd_ack_o) else report_error("timeout waiting for the command ack to drop");
  endtask

  task automatic fill_tlb(input logic [VTAG_W-1:0] vtag, input logic [PTAG_W-1:0] ptag,
                          input logic u, input logic w);
    @(posedge clk_i);
    tlb_fill_v_i    <= 1'b1;
    tlb_fill_vtag_i <= vtag;
    tlb_fill_ptag_i <= ptag;
    tlb_fill_u_i    <= u;
    tlb_fill_w_i    <= w;
    @(posedge clk_i);
    tlb_fill_v_i <= 1'b0;
  endtask

  task automatic flush_tlb();
    @(posedge clk_i);
    tlb_flush_i <= 1'b1;
    @(posedge clk_i);
    tlb_flush_i <= 1'b0;
  endtask

  // Fills and flushes need an empty pipeline
  task automatic wait_drain();
    int n;
    n = 0;
    while (code_q.size() != 0 && n < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      n++;
    end
    assert (code_q.size() == 0) else report_error("timeout waiting for outstanding responses");
  endtask

  initial begin : collect
    int                d;
    int                n;
    logic [NAME_W-1:0] name;
    logic [2:0]        exp_code;
    logic [DATA_W-1:0] exp_rdata;
    forever begin
      @(posedge clk_i);
      if (!reset_i && resp_req_o) begin
        assert (code_q.size() != 0)
          else report_error("response arrived with no command outstanding");
        name      = name_q.pop_front();
        exp_code  = code_q.pop_front();
        exp_rdata = rdata_q.pop_front();
        assert (resp_code_o == exp_code) else report_error($sformatf(
          "[FAIL] %0s: code expected %0d, actual %0d", name, exp_code, resp_code_o));
        assert (resp_rdata_o == exp_rdata) else report_error($sformatf(
          "[FAIL] %0s: rdata expected %08h, actual %08h", name, exp_rdata, resp_rdata_o));
        checked++;
        // Slow consumer, 0 to 3 cycles
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(posedge clk_i);
        resp_ack_i <= 1'b1;
        n = 0;
        @(posedge clk_i);
        while (resp_req_o && n < TIMEOUT_CYCLES) begin
          @(posedge clk_i);
          n++;
        end
        assert (!resp_req_o) else report_error("timeout waiting for the response request to drop");
        resp_ack_i <= 1'b0;
      end
    end
  end

  initial begin : stimulus
    int                 fd;
    int                 got;
    int                 cnt;
    string              line_s;
    logic [KIND_W-1:0]  kind_s;
    logic [NAME_W-1:0]  name_s;
    logic               op_v;
    logic [1:0]         priv_v;
    logic               sum_v;
    logic [VADDR_W-1:0] vaddr_v;
    logic [DATA_W-1:0]  wdata_v;
    logic [2:0]         code_v;
    logic [DATA_W-1:0]  rdata_v;
    logic [VTAG_W-1:0]  vtag_v;
    logic [PTAG_W-1:0]  ptag_v;
    logic               u_v;
    logic               w_v;

    seed            = 30;
    reset_i         = 1'b1;
    cmd_req_i       = 1'b0;
    cmd_op_i        = OP_LOAD;
    cmd_vaddr_i     = '0;
    cmd_wdata_i     = '0;
    priv_i          = PRIV_M;
    sum_i           = 1'b0;
    tlb_fill_v_i    = 1'b0;
    tlb_fill_vtag_i = '0;
    tlb_fill_ptag_i = '0;
    tlb_fill_u_i    = 1'b0;
    tlb_fill_w_i    = 1'b0;
    tlb_flush_i     = 1'b0;
    resp_ack_i      = 1'b0;

    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    fd = $fopen("verif/mem_unit_tests.txt", "r");
    assert (fd != 0) else report_error("could not open verif/mem_unit_tests.txt");
    got = $fgets(line_s, fd);
    while (got != 0) begin
      cnt = $sscanf(line_s, "%s", kind_s);
      if (cnt >= 1 && kind_s != KIND_NOTE) begin
        if (kind_s == KIND_FILL) begin
          cnt = $sscanf(line_s, "%s %s %h %h %d %d", kind_s, name_s, vtag_v, ptag_v, u_v, w_v);
          assert (cnt == 6) else report_error("malformed fill line in the test file");
          wait_drain();
          fill_tlb(vtag_v, ptag_v, u_v, w_v);
        end else if (kind_s == KIND_FLUSH) begin
          wait_drain();
          flush_tlb();
        end else if (kind_s == KIND_ACCESS) begin
          cnt = $sscanf(line_s, "%s %s %d %d %d %h %h %d %h", kind_s, name_s, op_v, priv_v,
                        sum_v, vaddr_v, wdata_v, code_v, rdata_v);
          assert (cnt == 9) else report_error("malformed access line in the test file");
          name_q.push_back(name_s);
          code_q.push_back(code_v);
          rdata_q.push_back(rdata_v);
          send_command(op_v, priv_v, sum_v, vaddr_v, wdata_v);
        end else begin
          report_error("unknown line kind in the test file");
        end
      end
      got = $fgets(line_s, fd);
    end
    $fclose(fd);

    wait_drain();
    $display("%0d responses checked", checked);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mem_unit_top.sv */
// Data-side memory unit chaining accept, translate, check, memory and response stages
`timescale 1ns/10ps
`default_nettype none

module mem_unit_top
  import mem_unit_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               cmd_req_i,
  input  wire mem_op_e            cmd_op_i,
  input  wire logic [VADDR_W-1:0] cmd_vaddr_i,
  input  wire logic [DATA_W-1:0]  cmd_wdata_i,
  input  wire priv_e              priv_i,
  input  wire logic               sum_i,
  output logic                    cmd_ack_o,
  input  wire logic               tlb_fill_v_i,
  input  wire logic [VTAG_W-1:0]  tlb_fill_vtag_i,
  input  wire logic [PTAG_W-1:0]  tlb_fill_ptag_i,
  input  wire logic               tlb_fill_u_i,
  input  wire logic               tlb_fill_w_i,
  input  wire logic               tlb_flush_i,
  output logic                    resp_req_o,
  output resp_code_e              resp_code_o,
  output logic [DATA_W-1:0]       resp_rdata_o,
  input  wire logic               resp_ack_i
);

  // Accept to translate
  logic               acc_valid;
  mem_op_e            acc_op;
  logic [VADDR_W-1:0] acc_vaddr;
  logic [DATA_W-1:0]  acc_wdata;
  priv_e              acc_priv;
  logic               acc_sum;
  logic               tr_ready;

  // Translate to fault check
  logic                  tr_valid;
  mem_op_e               tr_op;
  logic [PAGE_OFF_W-1:0] tr_offset;
  logic [DATA_W-1:0]     tr_wdata;
  priv_e                 tr_priv;
  logic                  tr_sum;
  logic                  tr_hit;
  logic                  tr_translated;
  logic [PTAG_W-1:0]     tr_ptag;
  logic                  tr_u;
  logic                  tr_w;
  logic                  fc_ready;

  // Fault check to data stage
  logic                   fc_valid;
  mem_op_e                fc_op;
  logic [WORD_ADDR_W-1:0] fc_waddr;
  logic [DATA_W-1:0]      fc_wdata;
  resp_code_e             fc_code;
  logic                   ds_ready;

  // Data stage to response sender
  logic              ds_valid;
  resp_code_e        ds_code;
  logic [DATA_W-1:0] ds_rdata;
  logic              rs_ready;

  mem_cmd_accept u_accept (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_vaddr_i (cmd_vaddr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .priv_i      (priv_i),
    .sum_i       (sum_i),
    .ready_i     (tr_ready),
    .cmd_ack_o   (cmd_ack_o),
    .valid_o     (acc_valid),
    .op_o        (acc_op),
    .vaddr_o     (acc_vaddr),
    .wdata_o     (acc_wdata),
    .priv_o      (acc_priv),
    .sum_o       (acc_sum)
  );

  mem_translate u_translate (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .valid_i         (acc_valid),
    .op_i            (acc_op),
    .vaddr_i         (acc_vaddr),
    .wdata_i         (acc_wdata),
    .priv_i          (acc_priv),
    .sum_i           (acc_sum),
    .ready_i         (fc_ready),
    .tlb_fill_v_i    (tlb_fill_v_i),
    .tlb_fill_vtag_i (tlb_fill_vtag_i),
    .tlb_fill_ptag_i (tlb_fill_ptag_i),
    .tlb_fill_u_i    (tlb_fill_u_i),
    .tlb_fill_w_i    (tlb_fill_w_i),
    .tlb_flush_i     (tlb_flush_i),
    .ready_o         (tr_ready),
    .valid_o         (tr_valid),
    .op_o            (tr_op),
    .offset_o        (tr_offset),
    .wdata_o         (tr_wdata),
    .priv_o          (tr_priv),
    .sum_o           (tr_sum),
    .hit_o           (tr_hit),
    .translated_o    (tr_translated),
    .ptag_o          (tr_ptag),
    .u_o             (tr_u),
    .w_o             (tr_w)
  );

  mem_fault_check u_fault_check (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (tr_valid),
    .op_i         (tr_op),
    .offset_i     (tr_offset),
    .wdata_i      (tr_wdata),
    .priv_i       (tr_priv),
    .sum_i        (tr_sum),
    .hit_i        (tr_hit),
    .translated_i (tr_translated),
    .ptag_i       (tr_ptag),
    .u_i          (tr_u),
    .w_i          (tr_w),
    .ready_i      (ds_ready),
    .ready_o      (fc_ready),
    .valid_o      (fc_valid),
    .op_o         (fc_op),
    .waddr_o      (fc_waddr),
    .wdata_o      (fc_wdata),
    .code_o       (fc_code)
  );

  mem_data_stage u_data_stage (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (fc_valid),
    .op_i    (fc_op),
    .waddr_i (fc_waddr),
    .wdata_i (fc_wdata),
    .code_i  (fc_code),
    .ready_i (rs_ready),
    .ready_o (ds_ready),
    .valid_o (ds_valid),
    .code_o  (ds_code),
    .rdata_o (ds_rdata)
  );

  mem_resp_send u_resp_send (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (ds_valid),
    .code_i       (ds_code),
    .rdata_i      (ds_rdata),
    .resp_ack_i   (resp_ack_i),
    .ready_o      (rs_ready),
    .resp_req_o   (resp_req_o),
    .resp_code_o  (resp_code_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

`default_nettype wire

/* rtl/mem_resp_send.sv */
// Response sender holding one finished response on a four-phase handshake
`timescale 1ns/10ps
`default_nettype none

module mem_resp_send
  import mem_unit_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              valid_i,
  input  wire resp_code_e        code_i,
  input  wire logic [DATA_W-1:0] rdata_i,
  input  wire logic              resp_ack_i,
  output logic                   ready_o,
  output logic                   resp_req_o,
  output resp_code_e             resp_code_o,
  output logic [DATA_W-1:0]      resp_rdata_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_LOW
  } state_e;

  state_e state_q;

  assign ready_o    = (state_q == S_IDLE);
  assign resp_req_o = (state_q == S_REQ);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (valid_i) state_q <= S_REQ;
        S_REQ:   if (resp_ack_i) state_q <= S_WAIT_LOW;
        default: if (!resp_ack_i) state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      resp_code_o  <= code_i;
      resp_rdata_o <= rdata_i;
    end
  end

  a_resp_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (resp_req_o && $past(resp_req_o)) |-> ($stable(resp_code_o) && $stable(resp_rdata_o))
  );

endmodule

`default_nettype wire

/* rtl/mem_data_stage.sv */
// Data memory stage writing good stores and reading good loads
`timescale 1ns/10ps
`default_nettype none

module mem_data_stage
  import mem_unit_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   valid_i,
  input  wire mem_op_e                op_i,
  input  wire logic [WORD_ADDR_W-1:0] waddr_i,
  input  wire logic [DATA_W-1:0]      wdata_i,
  input  wire resp_code_e             code_i,
  input  wire logic                   ready_i,
  output logic                        ready_o,
  output logic                        valid_o,
  output resp_code_e                  code_o,
  output logic [DATA_W-1:0]           rdata_o
);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              take;
  logic              good;

  assign ready_o = !valid_o || ready_i;
  assign take    = valid_i && ready_o;
  assign good    = (code_i == RESP_OK);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (ready_o) begin
        valid_o <= valid_i;
      end
      if (take && good && (op_i == OP_STORE)) begin
        mem[waddr_i] <= wdata_i;
      end
    end
  end

  // Faulted and store responses carry zero data
  always_ff @(posedge clk_i) begin
    if (take) begin
      code_o  <= code_i;
      rdata_o <= (good && (op_i == OP_LOAD)) ? mem[waddr_i] : '0;
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_fault_check.sv */
// Permission and range check stage producing the word address and response code
`timescale 1ns/10ps
`default_nettype none

module mem_fault_check
  import mem_unit_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  valid_i,
  input  wire mem_op_e               op_i,
  input  wire logic [PAGE_OFF_W-1:0] offset_i,
  input  wire logic [DATA_W-1:0]     wdata_i,
  input  wire priv_e                 priv_i,
  input  wire logic                  sum_i,
  input  wire logic                  hit_i,
  input  wire logic                  translated_i,
  input  wire logic [PTAG_W-1:0]     ptag_i,
  input  wire logic                  u_i,
  input  wire logic                  w_i,
  input  wire logic                  ready_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output mem_op_e                    op_o,
  output logic [WORD_ADDR_W-1:0]     waddr_o,
  output logic [DATA_W-1:0]          wdata_o,
  output resp_code_e                 code_o
);

  logic [PADDR_W-1:0] paddr;
  logic               priv_fault;
  resp_code_e         code_d;

  assign ready_o = !valid_o || ready_i;
  assign paddr   = {ptag_i, offset_i};

  assign priv_fault = translated_i &&
                      (((priv_i == PRIV_U) && !u_i) || ((priv_i == PRIV_S) && u_i && !sum_i));

  // Miss, privilege, write, then range
  always_comb begin
    if (!hit_i) begin
      code_d = RESP_TLB_MISS;
    end else if ((op_i == OP_LOAD) && priv_fault) begin
      code_d = RESP_LOAD_PAGE_FAULT;
    end else if ((op_i == OP_STORE) && (priv_fault || !w_i)) begin
      code_d = RESP_STORE_PAGE_FAULT;
    end else if (ptag_i >= PTAG_W'(MEM_WORDS >> (PAGE_OFF_W - 2))) begin
      code_d = RESP_ACCESS_FAULT;
    end else begin
      code_d = RESP_OK;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      op_o    <= op_i;
      waddr_o <= paddr[WORD_ADDR_W+1:2];
      wdata_o <= wdata_i;
      code_o  <= code_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_translate.sv */
// TLB with fill, flush and round-robin replacement plus the registered lookup stage
`timescale 1ns/10ps
`default_nettype none

module mem_translate
  import mem_unit_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  valid_i,
  input  wire mem_op_e               op_i,
  input  wire logic [VADDR_W-1:0]    vaddr_i,
  input  wire logic [DATA_W-1:0]     wdata_i,
  input  wire priv_e                 priv_i,
  input  wire logic                  sum_i,
  input  wire logic                  ready_i,
  input  wire logic                  tlb_fill_v_i,
  input  wire logic [VTAG_W-1:0]     tlb_fill_vtag_i,
  input  wire logic [PTAG_W-1:0]     tlb_fill_ptag_i,
  input  wire logic                  tlb_fill_u_i,
  input  wire logic                  tlb_fill_w_i,
  input  wire logic                  tlb_flush_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output mem_op_e                    op_o,
  output logic [PAGE_OFF_W-1:0]      offset_o,
  output logic [DATA_W-1:0]          wdata_o,
  output priv_e                      priv_o,
  output logic                       sum_o,
  output logic                       hit_o,
  output logic                       translated_o,
  output logic [PTAG_W-1:0]          ptag_o,
  output logic                       u_o,
  output logic                       w_o
);

  logic [TLB_ENTRIES-1:0] tlb_v_q;
  logic [VTAG_W-1:0]      tlb_vtag_q [TLB_ENTRIES];
  logic [PTAG_W-1:0]      tlb_ptag_q [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] tlb_u_q;
  logic [TLB_ENTRIES-1:0] tlb_w_q;
  logic [TLB_IDX_W-1:0]   rr_q;

  logic [VTAG_W-1:0]      look_vtag;
  logic [TLB_ENTRIES-1:0] look_match;
  logic [TLB_IDX_W-1:0]   look_idx;
  logic                   fill_hit;
  logic [TLB_IDX_W-1:0]   fill_idx;
  logic                   xlate_on;

  assign look_vtag = vaddr_i[VADDR_W-1:PAGE_OFF_W];
  assign xlate_on  = (priv_i != PRIV_M);
  assign ready_o   = !valid_o || ready_i;

  always_comb begin
    look_match = '0;
    look_idx   = '0;
    fill_hit   = 1'b0;
    fill_idx   = rr_q;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      look_match[i] = tlb_v_q[i] && (tlb_vtag_q[i] == look_vtag);
      if (look_match[i]) begin
        look_idx = TLB_IDX_W'(i);
      end
      // Refill of a present vtag reuses its slot
      if (tlb_v_q[i] && (tlb_vtag_q[i] == tlb_fill_vtag_i)) begin
        fill_hit = 1'b1;
        fill_idx = TLB_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tlb_v_q <= '0;
      rr_q    <= '0;
      valid_o <= 1'b0;
    end else begin
      if (tlb_flush_i) begin
        tlb_v_q <= '0;
      end
      if (tlb_fill_v_i) begin
        tlb_v_q[fill_idx] <= 1'b1;
        if (!fill_hit) begin
          rr_q <= rr_q + 1'b1;
        end
      end
      if (ready_o) begin
        valid_o <= valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlb_fill_v_i) begin
      tlb_vtag_q[fill_idx] <= tlb_fill_vtag_i;
      tlb_ptag_q[fill_idx] <= tlb_fill_ptag_i;
      tlb_u_q[fill_idx]    <= tlb_fill_u_i;
      tlb_w_q[fill_idx]    <= tlb_fill_w_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      op_o         <= op_i;
      offset_o     <= vaddr_i[PAGE_OFF_W-1:0];
      wdata_o      <= wdata_i;
      priv_o       <= priv_i;
      sum_o        <= sum_i;
      translated_o <= xlate_on;
      // Machine mode passes the address through with open permissions
      hit_o        <= xlate_on ? |look_match : 1'b1;
      ptag_o       <= xlate_on ? tlb_ptag_q[look_idx] : vaddr_i[PADDR_W-1:PAGE_OFF_W];
      u_o          <= xlate_on ? tlb_u_q[look_idx] : 1'b1;
      w_o          <= xlate_on ? tlb_w_q[look_idx] : 1'b1;
    end
  end

  a_tlb_unique: assert property (
    @(posedge clk_i) disable iff (reset_i) valid_i |-> $onehot0(look_match)
  );

endmodule

`default_nettype wire

/* rtl/mem_cmd_accept.sv */
// Command receiver taking four-phase requests into the first pipeline register
`timescale 1ns/10ps
`default_nettype none

module mem_cmd_accept
  import mem_unit_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               cmd_req_i,
  input  wire mem_op_e            cmd_op_i,
  input  wire logic [VADDR_W-1:0] cmd_vaddr_i,
  input  wire logic [DATA_W-1:0]  cmd_wdata_i,
  input  wire priv_e              priv_i,
  input  wire logic               sum_i,
  input  wire logic               ready_i,
  output logic                    cmd_ack_o,
  output logic                    valid_o,
  output mem_op_e                 op_o,
  output logic [VADDR_W-1:0]      vaddr_o,
  output logic [DATA_W-1:0]       wdata_o,
  output priv_e                   priv_o,
  output logic                    sum_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACK,
    S_WAIT_LOW
  } state_e;

  state_e state_q;
  logic   load;

  // Take a request only with room in the stage register
  assign load      = (state_q == S_IDLE) && cmd_req_i && (!valid_o || ready_i);
  assign cmd_ack_o = (state_q == S_ACK);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // A request held high through reset is not taken
      state_q <= S_WAIT_LOW;
      valid_o <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE:     if (load) state_q <= S_ACK;
        S_ACK:      if (!cmd_req_i) state_q <= S_IDLE;
        default:    if (!cmd_req_i) state_q <= S_IDLE;
      endcase
      if (load) begin
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      op_o    <= cmd_op_i;
      vaddr_o <= cmd_vaddr_i;
      wdata_o <= cmd_wdata_i;
      priv_o  <= priv_i;
      sum_o   <= sum_i;
    end
  end

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i) $rose(cmd_ack_o) |-> cmd_req_i
  );

endmodule

`default_nettype wire

/* rtl/mem_unit_pkg.sv */
// Memory unit shared widths, encodings and TLB sizing
`default_nettype none

package mem_unit_pkg;

  // Address split
  localparam int VADDR_W    = 16;
  localparam int PAGE_OFF_W = 8;
  localparam int VTAG_W     = 8;
  localparam int PTAG_W     = 5;
  localparam int PADDR_W    = 13;

  localparam int DATA_W      = 32;
  localparam int MEM_WORDS   = 1024;
  localparam int WORD_ADDR_W = 10;

  localparam int TLB_ENTRIES = 4;
  localparam int TLB_IDX_W   = 2;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    RESP_OK               = 3'd0,
    RESP_TLB_MISS         = 3'd1,
    RESP_LOAD_PAGE_FAULT  = 3'd2,
    RESP_STORE_PAGE_FAULT = 3'd3,
    RESP_ACCESS_FAULT     = 3'd4
  } resp_code_e;

endpackage

`default_nettype wire
